/* test/analogizer_trace.txt */
# T name | W addr wdata exp_sc_fx | R addr exp_rd_data exp_sc_fx  (hex)
# V mode r g b hsync vsync csync blank_n ce_pix exp_bank3 exp_bank2 exp_bank1  (hex, pins 4 clocks on)
T settings
W F7000000 9CEA1234 2
R F7000000 9CEA0000 2
R F6000000 00000000 2
R F7000001 00000000 2
W F6000000 FFFF0000 2
R F7000000 9CEA0000 2
W F7000000 4C1F0000 2
R F7000000 4C1F0000 2
T rgbs
W F7000000 00000000 2
R F7000000 00000000 2
V 0 FC 80 04 1 1 0 1 1 FD E0 20
V 0 40 C4 FF 0 1 1 1 1 43 F1 1F
V 0 FF FF FF 1 0 0 0 1 01 00 20
V 0 88 10 6C 1 1 1 1 0 8B C4 2D
T rgsb
W F7000000 04000000 2
R F7000000 04000000 2
V 1 FC 80 04 1 1 0 1 1 FE E0 00
V 1 40 C4 FF 1 1 1 1 1 43 F1 3F
V 1 FF FF FF 1 1 0 0 1 02 00 00
T ypbpr
W F7000000 08000000 2
R F7000000 08000000 2
V 2 FF FF FF 1 1 1 1 1 83 7F 30
V 2 00 00 00 1 1 0 1 1 82 40 10
V 2 FF 00 00 1 1 1 1 1 FF D2 2A
V 2 00 00 FF 1 1 1 1 1 6F C7 1F
V 2 00 FF 00 1 1 0 1 1 16 E4 25
V 2 FF FF FF 1 1 1 0 1 83 40 10
T unused_mode
W F7000000 10000000 2
R F7000000 10000000 2
V 4 FF FF FF 0 1 1 1 1 01 40 20
V 4 FF FF FF 1 1 1 0 1 03 00 00
V 4 FF FF FF 1 1 1 1 1 03 40 20
V 4 FF FF FF 0 1 1 1 0 01 40 20
V 4 FF FF FF 0 1 1 1 1 01 40 00
T scanline_hold
W F7000000 24000000 4
R F7000000 24000000 4
W F7000000 00000000 4
R F7000000 00000000 4

/* list.f */
hdl/analogizer_pkg.sv
hdl/analogizer_settings.sv
hdl/sync_blank_path.sv
hdl/ypbpr_converter.sv
hdl/cart_video_driver.sv
hdl/analogizer_top.sv
test/tb_analogizer.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_analogizer
RTL_TOP   := analogizer_top
FILELIST  := list.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_analogizer.sv */
// Reads test/analogizer_trace.txt from the project root; pins are checked 4 clocks after each vector
`timescale 1ns/1ps

module tb_analogizer;
	import analogizer_pkg::*;

	localparam int    TIMEOUT_CYCLES = 50;
	localparam string TRACE_FILE     = "test/analogizer_trace.txt";
	localparam logic [31:0] HIT_ADDR = {SETTINGS_ADDR_DEFAULT, 24'h0};

	logic        i_clk;
	logic        i_rst;
	logic        i_ena;
	logic [7:0]  i_r;
	logic [7:0]  i_g;
	logic [7:0]  i_b;
	logic        i_hsync;
	logic        i_vsync;
	logic        i_csync;
	logic        i_blank_n;
	logic        i_ce_pix;
	logic [31:0] i_bridge_addr;
	logic        i_bridge_rd;
	logic        i_bridge_wr;
	logic [31:0] i_bridge_wr_data;
	logic [31:0] o_bridge_rd_data;
	settings_t   o_settings;
	logic [2:0]  o_sc_fx;
	logic [7:0]  o_cart_bank1;
	logic [7:0]  o_cart_bank2;
	logic [7:0]  o_cart_bank3;
	logic        o_cart_bank1_dir;
	logic        o_cart_bank2_dir;
	logic        o_cart_bank3_dir;

	int          errors = 0;
	int          cyc = 0;             // Negedge count
	logic [23:0] exp_q [$];           // Expected {bank3, bank2, bank1}
	int          due_q [$];           // Negedge at which to check
	int          line_q [$];          // Trace line for messages
	bit          pclk_par = 1'b0;     // Model of the pixel clock pin
	int          tests_run = 0;
	int          tests_failed = 0;
	string       cur_test = "";
	int          test_err0 = 0;       // Error count when the test began
	int          fd;
	int          rc;
	int          line_no = 0;
	int          waited;
	string       line;
	logic [31:0] f [12];              // Parsed hex columns

	analogizer_top UUT (
		.i_clk            (i_clk),
		.i_rst            (i_rst),
		.i_ena            (i_ena),
		.i_r              (i_r),
		.i_g              (i_g),
		.i_b              (i_b),
		.i_hsync          (i_hsync),
		.i_vsync          (i_vsync),
		.i_csync          (i_csync),
		.i_blank_n        (i_blank_n),
		.i_ce_pix         (i_ce_pix),
		.i_bridge_addr    (i_bridge_addr),
		.i_bridge_rd      (i_bridge_rd),
		.i_bridge_wr      (i_bridge_wr),
		.i_bridge_wr_data (i_bridge_wr_data),
		.o_bridge_rd_data (o_bridge_rd_data),
		.o_settings       (o_settings),
		.o_sc_fx          (o_sc_fx),
		.o_cart_bank1     (o_cart_bank1),
		.o_cart_bank2     (o_cart_bank2),
		.o_cart_bank3     (o_cart_bank3),
		.o_cart_bank1_dir (o_cart_bank1_dir),
		.o_cart_bank2_dir (o_cart_bank2_dir),
		.o_cart_bank3_dir (o_cart_bank3_dir)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk; // 100 ns period
	end

	// Floor division by 64, as an arithmetic shift would give
	function automatic int floor_div64(input int v);
		if (v >= 0) begin
			return v / 64;
		end
		return -((-v + 63) / 64);
	endfunction

	function automatic int clamp_0_63(input int v);
		if (v < 0) begin
			return 0;
		end
		return (v > 63) ? 63 : v;
	endfunction

	// Expected pins for one vector, straight from the mode table
	function automatic logic [23:0] model_banks(input int mode, input int r8, input int g8,
		input int b8, input bit hs, input bit cs, input bit bn, input bit pclk);
		int         r;
		int         g;
		int         b;
		int         c0;
		int         c1;
		int         c2;
		bit         hp;
		bit         vp;
		bit         bp;
		logic [5:0] q0;
		logic [5:0] q1;
		logic [5:0] q2;
		r = bn ? r8 / 4 : 0; // Top 6 bits, black in blanking
		g = bn ? g8 / 4 : 0;
		b = bn ? b8 / 4 : 0;
		case (mode)
			0, 1: begin
				c0 = r;
				c1 = g;
				c2 = b;
				hp = (mode == 0) ? cs : 1'b1;
				vp = (mode == 0) ? 1'b1 : cs;
				bp = bn;
			end
			2: begin
				c0 = clamp_0_63(floor_div64(PR_WR * r + PR_WG * g + PR_WB * b) + CHROMA_MID);
				c1 = clamp_0_63(floor_div64(Y_WR * r + Y_WG * g + Y_WB * b));
				c2 = clamp_0_63(floor_div64(PB_WR * r + PB_WG * g + PB_WB * b) + CHROMA_MID);
				hp = 1'b1;
				vp = cs;
				bp = 1'b1; // Never blanked in YPbPr
			end
			default: begin
				c0 = 0;
				c1 = 0;
				c2 = 0;
				hp = hs; // Raw Hsync
				vp = 1'b1;
				bp = bn;
			end
		endcase
		q0 = 6'(c0);
		q1 = 6'(c1);
		q2 = 6'(c2);
		return {q0, hp, vp, q2[0], bp, q1, 2'b00, pclk, q2[5:1]};
	endfunction

	task automatic check_parked(input string when);
		assert ({o_cart_bank3_dir, o_cart_bank2_dir, o_cart_bank1_dir} == 3'b000) else begin
			errors++;
			$display("MISMATCH %s bank_dir got %h expected 0", when,
				{o_cart_bank3_dir, o_cart_bank2_dir, o_cart_bank1_dir});
		end
		assert ({o_cart_bank3, o_cart_bank2, o_cart_bank1} == 24'h0) else begin
			errors++;
			$display("MISMATCH %s o_cart_bank3..1 got %h expected 000000", when,
				{o_cart_bank3, o_cart_bank2, o_cart_bank1});
		end
	endtask

	// Compare pins with the oldest expected word when it falls due
	always @(negedge i_clk) begin
		cyc = cyc + 1;
		while (due_q.size() > 0 && due_q[0] == cyc) begin
			assert (o_cart_bank3 == exp_q[0][23:16]) else begin
				errors++;
				$display("MISMATCH line %0d o_cart_bank3 got %h expected %h", line_q[0],
					o_cart_bank3, exp_q[0][23:16]);
			end
			assert (o_cart_bank2 == exp_q[0][15:8]) else begin
				errors++;
				$display("MISMATCH line %0d o_cart_bank2 got %h expected %h", line_q[0],
					o_cart_bank2, exp_q[0][15:8]);
			end
			assert (o_cart_bank1 == exp_q[0][7:0]) else begin
				errors++;
				$display("MISMATCH line %0d o_cart_bank1 got %h expected %h", line_q[0],
					o_cart_bank1, exp_q[0][7:0]);
			end
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
			void'(line_q.pop_front());
		end
	end

	// Let every pixel in flight reach the pins
	task automatic drain_pipeline();
		int n;
		n = 0;
		while (due_q.size() > 0 && n < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			i_ce_pix <= 1'b0;
			n++;
		end
		if (due_q.size() > 0) begin
			errors++;
			$display("Timeout while waiting for %0d pixels to reach the pins", due_q.size());
		end
	endtask

	// One bridge strobe, read data checked the cycle after
	task automatic bridge_access(input bit is_write, input logic [31:0] addr,
		input logic [31:0] data, input logic [2:0] exp_sc, input int ln);
		drain_pipeline();
		@(posedge i_clk);
		i_ce_pix         <= 1'b0;
		i_bridge_addr    <= addr;
		i_bridge_wr_data <= is_write ? data : 32'h0;
		i_bridge_wr      <= is_write;
		i_bridge_rd      <= !is_write;
		@(posedge i_clk);
		i_bridge_wr <= 1'b0;
		i_bridge_rd <= 1'b0;
		@(negedge i_clk);
		if (!is_write) begin
			assert (o_bridge_rd_data == data) else begin
				errors++;
				$display("MISMATCH line %0d o_bridge_rd_data got %h expected %h", ln,
					o_bridge_rd_data, data);
			end
			if (addr == HIT_ADDR) begin
				assert (o_settings == data[31:16]) else begin
					errors++;
					$display("MISMATCH line %0d o_settings got %h expected %h", ln,
						o_settings, data[31:16]);
				end
			end
		end
		assert (o_sc_fx == exp_sc) else begin
			errors++;
			$display("MISMATCH line %0d o_sc_fx got %h expected %h", ln, o_sc_fx, exp_sc);
		end
	endtask

	task automatic drive_video(input int ln);
		logic [23:0] model;
		@(posedge i_clk);
		assert (o_settings.video_type == f[0][3:0]) else begin
			errors++;
			$display("MISMATCH line %0d video_type got %h expected %h", ln,
				o_settings.video_type, f[0][3:0]);
		end
		i_r       <= f[1][7:0];
		i_g       <= f[2][7:0];
		i_b       <= f[3][7:0];
		i_hsync   <= f[4][0];
		i_vsync   <= f[5][0];
		i_csync   <= f[6][0];
		i_blank_n <= f[7][0];
		i_ce_pix  <= f[8][0];
		pclk_par = pclk_par ^ f[8][0];
		model = model_banks(f[0], f[1], f[2], f[3], f[4][0], f[6][0], f[7][0], pclk_par);
		assert (model == {f[9][7:0], f[10][7:0], f[11][7:0]}) else begin
			errors++;
			$display("Trace line %0d disagrees with the model, which gives %h", ln, model);
		end
		exp_q.push_back({f[9][7:0], f[10][7:0], f[11][7:0]});
		due_q.push_back(cyc + 5); // Pins update on the 4th edge after this one
		line_q.push_back(ln);
	endtask

	task automatic finish_test();
		if (cur_test != "") begin
			drain_pipeline();
			tests_run++;
			if (errors > test_err0) begin
				tests_failed++;
				$display("test %s: failed with %0d errors", cur_test, errors - test_err0);
			end else begin
				$display("test %s: ok", cur_test);
			end
		end
		test_err0 = errors;
	endtask

	initial begin
		i_rst = 1'b1;
		i_ena = 1'b1; // Reset has to park the pins on its own
		i_r = '0;
		i_g = '0;
		i_b = '0;
		i_hsync = 1'b0;
		i_vsync = 1'b0;
		i_csync = 1'b0;
		i_blank_n = 1'b0;
		i_ce_pix = 1'b0;
		i_bridge_addr = '0;
		i_bridge_rd = 1'b0;
		i_bridge_wr = 1'b0;
		i_bridge_wr_data = '0;

		// Parking in reset and while disabled
		cur_test = "parking";
		for (int i = 0; i < 3; i++) begin
			@(negedge i_clk);
			check_parked("in reset");
		end
		@(posedge i_clk);
		i_rst <= 1'b0; // 4 edges of reset
		i_ena <= 1'b0; // Disabled from the first free cycle
		for (int i = 0; i < 3; i++) begin
			@(negedge i_clk);
			check_parked("disabled");
		end
		assert (o_bridge_rd_data == 32'h0 && o_settings == 16'h0 && o_sc_fx == 3'h0) else begin
			errors++;
			$display("Settings outputs are not zero after reset");
		end
		@(posedge i_clk);
		i_ena <= 1'b1;
		waited = 0;
		while (!(o_cart_bank1_dir && o_cart_bank2_dir && o_cart_bank3_dir)
			&& waited < TIMEOUT_CYCLES) begin
			@(negedge i_clk);
			waited++;
		end
		assert (waited == 3) else begin
			errors++;
			$display("Bank directions rose after %0d half-shifted cycles instead of 3", waited);
		end
		finish_test();

		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open %s", TRACE_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				line_no++;
				if (rc > 0 && line.len() > 1) begin
					case (line[0])
						"T": begin
							finish_test();
							cur_test = line.substr(2, line.len() - 1);
							while (cur_test.len() > 0 && (cur_test[cur_test.len()-1] == 8'h0A
								|| cur_test[cur_test.len()-1] == 8'h0D)) begin
								cur_test = cur_test.substr(0, cur_test.len() - 2);
							end
						end
						"W", "R": begin
							rc = $sscanf(line.substr(2, line.len() - 1), "%h %h %h",
								f[0], f[1], f[2]);
							if (rc != 3) begin
								errors++;
								$display("Trace line %0d is malformed", line_no);
							end else begin
								bridge_access(line[0] == "W", f[0], f[1], f[2][2:0], line_no);
							end
						end
						"V": begin
							rc = $sscanf(line, "V %h %h %h %h %h %h %h %h %h %h %h %h",
								f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
								f[10], f[11]);
							if (rc != 12) begin
								errors++;
								$display("Trace line %0d is malformed", line_no);
							end else begin
								drive_video(line_no);
							end
						end
						default: begin
						end // Comments and blank lines
					endcase
				end
			end
			$fclose(fd);
		end
		finish_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* hdl/analogizer_top.sv */
// Single clock; pins lag the video inputs by CONV_LATENCY+1 clocks and only the top 6 colour bits are used
`timescale 1ns/1ps

module analogizer_top #(
	parameter logic [7:0] SETTINGS_ADDR = analogizer_pkg::SETTINGS_ADDR_DEFAULT
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_ena,
	// Video in
	input  logic [7:0]                i_r,
	input  logic [7:0]                i_g,
	input  logic [7:0]                i_b,
	input  logic                      i_hsync,
	input  logic                      i_vsync,
	input  logic                      i_csync,
	input  logic                      i_blank_n,
	input  logic                      i_ce_pix,
	// Bridge
	input  logic [31:0]               i_bridge_addr,
	input  logic                      i_bridge_rd,
	input  logic                      i_bridge_wr,
	input  logic [31:0]               i_bridge_wr_data,
	output logic [31:0]               o_bridge_rd_data,
	// Settings
	output analogizer_pkg::settings_t o_settings,
	output logic [2:0]                o_sc_fx,
	// Cartridge port
	output logic [7:0]                o_cart_bank1,
	output logic [7:0]                o_cart_bank2,
	output logic [7:0]                o_cart_bank3,
	output logic                      o_cart_bank1_dir,
	output logic                      o_cart_bank2_dir,
	output logic                      o_cart_bank3_dir
);
	import analogizer_pkg::*;

	settings_t settings;   // Decoded word
	logic      enabled;    // Registered i_ena
	vid_beat_t in_beat;
	vid_beat_t rgb_beat;   // Blanked RGB, delayed
	vid_beat_t ypbpr_beat; // Converted

	// 8 to 6 bit colour
	assign in_beat.pix.c0  = i_r[7:2];
	assign in_beat.pix.c1  = i_g[7:2];
	assign in_beat.pix.c2  = i_b[7:2];
	assign in_beat.csync   = i_csync;
	assign in_beat.hsync   = i_hsync;
	assign in_beat.vsync   = i_vsync;
	assign in_beat.blank_n = i_blank_n;

	assign o_settings = settings;

	analogizer_settings #(
		.SETTINGS_ADDR(SETTINGS_ADDR)
	) u_settings (
		.i_clk            (i_clk),
		.i_rst            (i_rst),
		.i_ena            (i_ena),
		.i_bridge_addr    (i_bridge_addr),
		.i_bridge_rd      (i_bridge_rd),
		.i_bridge_wr      (i_bridge_wr),
		.i_bridge_wr_data (i_bridge_wr_data),
		.o_bridge_rd_data (o_bridge_rd_data),
		.o_settings       (settings),
		.o_sc_fx          (o_sc_fx),
		.o_enabled        (enabled)
	);

	sync_blank_path #(
		.DEPTH(CONV_LATENCY) // Match the converter
	) u_sync_blank (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_beat (in_beat),
		.o_beat (rgb_beat)
	);

	ypbpr_converter u_ypbpr (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_beat (in_beat),
		.o_beat (ypbpr_beat)
	);

	cart_video_driver u_cart (
		.i_clk            (i_clk),
		.i_rst            (i_rst),
		.i_enabled        (enabled),
		.i_mode           (video_mode_e'(settings.video_type)),
		.i_rgb_beat       (rgb_beat),
		.i_ypbpr_beat     (ypbpr_beat),
		.i_ce_pix         (i_ce_pix),
		.o_cart_bank1     (o_cart_bank1),
		.o_cart_bank2     (o_cart_bank2),
		.o_cart_bank3     (o_cart_bank3),
		.o_cart_bank1_dir (o_cart_bank1_dir),
		.o_cart_bank2_dir (o_cart_bank2_dir),
		.o_cart_bank3_dir (o_cart_bank3_dir)
	);

endmodule

/* hdl/cart_video_driver.sv */
// Both beats must arrive aligned; pins are registered and read 0 with direction 0 when parked
`timescale 1ns/1ps

module cart_video_driver (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_enabled,
	input  analogizer_pkg::video_mode_e i_mode,
	input  analogizer_pkg::vid_beat_t   i_rgb_beat,
	input  analogizer_pkg::vid_beat_t   i_ypbpr_beat,
	input  logic                        i_ce_pix,
	output logic [7:0]                  o_cart_bank1,
	output logic [7:0]                  o_cart_bank2,
	output logic [7:0]                  o_cart_bank3,
	output logic                        o_cart_bank1_dir,
	output logic                        o_cart_bank2_dir,
	output logic                        o_cart_bank3_dir
);
	import analogizer_pkg::*;

	pix_t       sel_pix;
	logic       sel_hs;      // To Hsync pin
	logic       sel_vs;      // To DAC sync pin
	logic       sel_blank_n;
	logic       pclk_tgl;    // Flips once per pixel
	logic [1:0] pclk_dly;    // With the toggle, 3 stages like the converter
	cart_word_u word_d;
	cart_word_u word_q;
	logic       dir_q;

	// Mode select
	always_comb begin
		case (i_mode)
			MODE_RGBS: begin
				sel_pix     = i_rgb_beat.pix;
				sel_hs      = i_rgb_beat.csync;
				sel_vs      = 1'b1;
				sel_blank_n = i_rgb_beat.blank_n;
			end
			MODE_RGSB: begin
				sel_pix     = i_rgb_beat.pix;
				sel_hs      = 1'b1;
				sel_vs      = i_rgb_beat.csync; // SOG switch on
				sel_blank_n = i_rgb_beat.blank_n;
			end
			MODE_YPBPR: begin
				sel_pix     = i_ypbpr_beat.pix;
				sel_hs      = 1'b1;
				sel_vs      = i_ypbpr_beat.csync;
				sel_blank_n = 1'b1; // DAC must not blank the sync level
			end
			default: begin
				sel_pix     = '0;  // Black
				sel_hs      = i_rgb_beat.hsync;
				sel_vs      = 1'b1;
				sel_blank_n = i_rgb_beat.blank_n;
			end
		endcase
	end

	// Pack by pin function
	always_comb begin
		word_d.fields.red       = sel_pix.c0;
		word_d.fields.hsync_pin = sel_hs;
		word_d.fields.vsync_pin = sel_vs;
		word_d.fields.blue0     = sel_pix.c2[0];
		word_d.fields.blank_n   = sel_blank_n;
		word_d.fields.green     = sel_pix.c1;
		word_d.fields.rsvd      = 2'b00;
		word_d.fields.pix_clk   = pclk_dly[1];
		word_d.fields.blue_hi   = sel_pix.c2[5:1];
	end

	// Pixel clock for the cartridge
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pclk_tgl <= 1'b0;
			pclk_dly <= '0;
		end else begin
			pclk_tgl <= pclk_tgl ^ i_ce_pix;
			pclk_dly <= {pclk_dly[0], pclk_tgl};
		end
	end

	// Output register and parking
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			word_q <= '0;
			dir_q  <= 1'b0; // Pins as inputs
		end else begin
			word_q <= i_enabled ? word_d : '0;
			dir_q  <= i_enabled;
		end
	end

	assign o_cart_bank3     = word_q.banks.bank3;
	assign o_cart_bank2     = word_q.banks.bank2;
	assign o_cart_bank1     = word_q.banks.bank1;
	assign o_cart_bank3_dir = dir_q;
	assign o_cart_bank2_dir = dir_q;
	assign o_cart_bank1_dir = dir_q;

endmodule

/* hdl/ypbpr_converter.sv */
// Fixed 3-clock latency and one pixel per clock; input colour is unsigned 6 bit
`timescale 1ns/1ps

module ypbpr_converter (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  analogizer_pkg::vid_beat_t i_beat,
	output analogizer_pkg::vid_beat_t o_beat
);
	import analogizer_pkg::*;

	pix_t              src;       // Blanked input colour
	logic signed [13:0] y_p  [3]; // Stage 1 products R, G, B
	logic signed [13:0] pb_p [3];
	logic signed [13:0] pr_p [3];
	logic signed [9:0]  y_s;      // Stage 2 scaled sums
	logic signed [9:0]  pb_s;
	logic signed [9:0]  pr_s;
	pix_t              out_pix;   // Stage 3 clamped
	logic [3:0]        ctl [3];   // {csync, hsync, vsync, blank_n} per stage

	// Unsigned channel times signed weight
	function automatic logic signed [13:0] wmul(input logic [5:0] c, input int w);
		wmul = 14'(int'({1'b0, c}) * w);
	endfunction

	// Sum of three products, scaled back to integer
	function automatic logic signed [9:0] wsum(input logic signed [13:0] a,
		input logic signed [13:0] b, input logic signed [13:0] c);
		logic signed [15:0] s;
		s    = 16'(a) + 16'(b) + 16'(c);
		wsum = 10'(s >>> WEIGHT_FRAC); // Floor
	endfunction

	function automatic logic [5:0] clamp6(input logic signed [9:0] v);
		if (v < 0) begin
			clamp6 = 6'd0;
		end else if (v > 10'sd63) begin
			clamp6 = 6'd63;
		end else begin
			clamp6 = v[5:0];
		end
	endfunction

	// Blanked pixels go in as black
	assign src = i_beat.blank_n ? i_beat.pix : '0;

	always_ff @(posedge i_clk) begin
		// Stage 1
		y_p[0]  <= wmul(src.c0, Y_WR);
		y_p[1]  <= wmul(src.c1, Y_WG);
		y_p[2]  <= wmul(src.c2, Y_WB);
		pb_p[0] <= wmul(src.c0, PB_WR);
		pb_p[1] <= wmul(src.c1, PB_WG);
		pb_p[2] <= wmul(src.c2, PB_WB);
		pr_p[0] <= wmul(src.c0, PR_WR);
		pr_p[1] <= wmul(src.c1, PR_WG);
		pr_p[2] <= wmul(src.c2, PR_WB);
		// Stage 2, chroma lifted to mid scale
		y_s  <= wsum(y_p[0], y_p[1], y_p[2]);
		pb_s <= wsum(pb_p[0], pb_p[1], pb_p[2]) + 10'(CHROMA_MID);
		pr_s <= wsum(pr_p[0], pr_p[1], pr_p[2]) + 10'(CHROMA_MID);
		// Stage 3
		out_pix.c0 <= clamp6(pr_s);
		out_pix.c1 <= clamp6(y_s);
		out_pix.c2 <= clamp6(pb_s);
	end

	// Timing rides alongside the maths
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < 3; i++) begin
				ctl[i] <= '0;
			end
		end else begin
			ctl[0] <= {i_beat.csync, i_beat.hsync, i_beat.vsync, i_beat.blank_n};
			ctl[1] <= ctl[0];
			ctl[2] <= ctl[1];
		end
	end

	assign o_beat.pix     = out_pix;
	assign o_beat.csync   = ctl[2][3];
	assign o_beat.hsync   = ctl[2][2];
	assign o_beat.vsync   = ctl[2][1];
	assign o_beat.blank_n = ctl[2][0];

endmodule

/* hdl/sync_blank_path.sv */
// DEPTH must be at least 1 and equal the converter latency so that both paths line up
`timescale 1ns/1ps

module sync_blank_path #(
	parameter int DEPTH = 3
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  analogizer_pkg::vid_beat_t i_beat,
	output analogizer_pkg::vid_beat_t o_beat
);
	import analogizer_pkg::*;

	vid_beat_t blanked;       // Input with colour cleared in blanking
	vid_beat_t pipe [DEPTH];  // Delay chain

	// Some cores leave colour on the bus during blanking
	always_comb begin
		blanked = i_beat;
		if (!i_beat.blank_n) begin
			blanked.pix = '0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe[i] <= '0; // Syncs low until real video arrives
			end
		end else begin
			pipe[0] <= blanked;
			for (int i = 1; i < DEPTH; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign o_beat = pipe[DEPTH-1]; // DEPTH clocks behind i_beat

endmodule

/* hdl/analogizer_settings.sv */
// Bridge writes land only at {SETTINGS_ADDR, 24'h0}; read data is valid the cycle after i_bridge_rd
`timescale 1ns/1ps

module analogizer_settings #(
	parameter logic [7:0] SETTINGS_ADDR = analogizer_pkg::SETTINGS_ADDR_DEFAULT
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_ena,
	input  logic [31:0]               i_bridge_addr,
	input  logic                      i_bridge_rd,
	input  logic                      i_bridge_wr,
	input  logic [31:0]               i_bridge_wr_data,
	output logic [31:0]               o_bridge_rd_data,
	output analogizer_pkg::settings_t o_settings,
	output logic [2:0]                o_sc_fx,
	output logic                      o_enabled
);
	import analogizer_pkg::*;

	settings_t settings_q; // Stored word
	settings_t wr_word;    // Word carried by the current write
	logic      addr_hit;

	// Only the top byte selects, the rest must be zero
	assign addr_hit = (i_bridge_addr == {SETTINGS_ADDR, 24'h0});

	// High byte from 31:24, low byte from 23:16
	assign wr_word = settings_t'(i_bridge_wr_data[31:16]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			settings_q <= '0; // Mode 0 is RGBS
			o_sc_fx    <= '0;
		end else if (i_bridge_wr && addr_hit) begin
			settings_q <= wr_word;
			// Scanline codes start at video type 5
			if (wr_word.video_type >= 4'd5) begin
				o_sc_fx <= 3'(wr_word.video_type - 4'd5);
			end // Lower codes keep the last effect
		end
	end

	// Read-back in the write byte lanes
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_bridge_rd_data <= '0;
		end else if (i_bridge_rd) begin
			if (addr_hit) begin
				o_bridge_rd_data <= {settings_q, 16'h0000};
			end else begin
				o_bridge_rd_data <= '0; // Foreign address
			end
		end
	end

	// Enable seen one clock late
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_enabled <= 1'b0;
		end else begin
			o_enabled <= i_ena;
		end
	end

	assign o_settings = settings_q; // Valid the cycle after the write

endmodule

/* hdl/analogizer_pkg.sv */
// Shared types for the video front end; colour is 6 bits per channel and the weights are Q6
package analogizer_pkg;

	// Video type field of the settings word
	typedef enum logic [3:0] {
		MODE_RGBS  = 4'd0,  // Csync on the Hsync pin
		MODE_RGSB  = 4'd1,  // Csync on the DAC sync pin
		MODE_YPBPR = 4'd2   // Converter output, sync on green
	} video_mode_e;         // Unlisted codes give black with plain Hsync

	// Settings word as written over the bridge, MSB first
	typedef struct packed {
		logic       osd;             // OSD active
		logic       blank_screen;    // Handheld screen blanking
		logic [3:0] video_type;      // Raw code, see video_mode_e
		logic [3:0] cont_assignment; // Controller to player map
		logic       ena;             // Adapter enable flag, reported only
		logic [4:0] cont_type;       // Controller type
	} settings_t;

	// One pixel, RGB or Pr/Y/Pb
	typedef struct packed {
		logic [5:0] c0; // R or Pr
		logic [5:0] c1; // G or Y
		logic [5:0] c2; // B or Pb
	} pix_t;

	// Pixel plus its timing
	typedef struct packed {
		pix_t pix;
		logic csync;
		logic hsync;
		logic vsync;
		logic blank_n;
	} vid_beat_t;

	typedef struct packed {
		logic [7:0] bank3;
		logic [7:0] bank2;
		logic [7:0] bank1;
	} cart_banks_t;

	// Same 24 pins seen as video signals
	typedef struct packed {
		logic [5:0] red;       // bank3[7:2]
		logic       hsync_pin; // bank3[1]
		logic       vsync_pin; // bank3[0] DAC sync
		logic       blue0;     // bank2[7]
		logic       blank_n;   // bank2[6]
		logic [5:0] green;     // bank2[5:0]
		logic [1:0] rsvd;      // bank1[7:6] tied low
		logic       pix_clk;   // bank1[5]
		logic [4:0] blue_hi;   // bank1[4:0] blue 5..1
	} cart_fields_t;

	typedef union packed {
		cart_banks_t  banks;
		cart_fields_t fields;
	} cart_word_u;

	localparam logic [7:0] SETTINGS_ADDR_DEFAULT = 8'hF7; // Top address byte

	// Converter weights with 6 fractional bits
	localparam int WEIGHT_FRAC = 6;
	localparam int Y_WR  = 19;
	localparam int Y_WG  = 37;
	localparam int Y_WB  = 8;
	localparam int PB_WR = -11;
	localparam int PB_WG = -21;
	localparam int PB_WB = 32;
	localparam int PR_WR = 32;
	localparam int PR_WG = -27;
	localparam int PR_WB = -5;
	localparam int CHROMA_MID   = 32; // Zero chroma level
	localparam int CONV_LATENCY = 3;  // Converter register stages

endpackage
